//--- Bender.yml
package:
  name: keylab

sources:
  - include_dirs:
      - src
    files:
      - src/keylab_pkg.sv
      - src/scan_event_decoder.sv
      - src/key_hold_bank.sv
      - src/cursor_mover.sv
      - src/lfsr_ticker.sv
      - src/keylab_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_keylab.sv

//--- flist.f
+incdir+src
src/keylab_pkg.sv
src/scan_event_decoder.sv
src/key_hold_bank.sv
src/cursor_mover.sv
src/lfsr_ticker.sv
src/keylab_top.sv
testbench/tb_clock_gen.sv
testbench/tb_keylab.sv

//--- src/cursor_mover.sv
`timescale 1ns/1ns
`default_nettype none

`include "keylab_consts.svh"

module cursor_mover
  import keylab_pkg::*;
#(
  parameter int unsigned step_cycles      = `DEFAULT_STEP_CYCLES,
  parameter int unsigned slow_step_cycles = `DEFAULT_SLOW_STEP_CYCLES
) (
  input  logic        CLK_25MHZ,
  input  logic        reset_from_key,
  input  key_word_u   held,
  output logic [9:0]  pointer_x,
  output logic [9:0]  pointer_y,
  output logic [11:0] cursor_rgb
);

  localparam logic [31:0] fast_period = step_cycles;
  localparam logic [31:0] slow_period = slow_step_cycles;

  logic [31:0] step_cnt;
  logic [31:0] period;
  logic        any_arrow;
  logic        step;
  logic        go_left;
  logic        go_right;
  logic        go_up;
  logic        go_down;
  logic        space_q;
  logic [1:0]  pal_idx;

  // opposite arrows cancel
  assign go_right  = held.keys.right & ~held.keys.left;
  assign go_left   = held.keys.left  & ~held.keys.right;
  assign go_down   = held.keys.down  & ~held.keys.up;
  assign go_up     = held.keys.up    & ~held.keys.down;
  assign any_arrow = held.keys.left | held.keys.right | held.keys.up | held.keys.down;

  assign period = held.keys.m ? slow_period : fast_period;   // m held means slow
  assign step   = any_arrow && (step_cnt >= period - 32'd1);  // >= covers slow to fast switch

  //////////////////////////////////////////////////////////////////////
  // step timing
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      step_cnt <= '0;
    end else if (!any_arrow || step) begin
      step_cnt <= '0;
    end else begin
      step_cnt <= step_cnt + 32'd1;
    end
  end

  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      pointer_x <= `CURSOR_HOME_X;
      pointer_y <= `CURSOR_HOME_Y;
    end else if (step) begin
      if (go_right && pointer_x < `SCREEN_W - 10'd1) begin
        pointer_x <= pointer_x + 10'd1;
      end else if (go_left && pointer_x != 10'd0) begin
        pointer_x <= pointer_x - 10'd1;
      end
      if (go_down && pointer_y < `SCREEN_H - 10'd1) begin   // y grows downward
        pointer_y <= pointer_y + 10'd1;
      end else if (go_up && pointer_y != 10'd0) begin
        pointer_y <= pointer_y - 10'd1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // colour cycling on space press
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      space_q <= 1'b0;
      pal_idx <= 2'd0;
    end else begin
      space_q <= held.keys.space;
      if (held.keys.space && !space_q) begin
        pal_idx <= pal_idx + 2'd1;   // wraps 3 -> 0
      end
    end
  end

  always_comb begin
    case (pal_idx)
      2'd0:    cursor_rgb = `PALETTE_0;
      2'd1:    cursor_rgb = `PALETTE_1;
      2'd2:    cursor_rgb = `PALETTE_2;
      default: cursor_rgb = `PALETTE_3;
    endcase
  end

  a_on_screen: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
    (pointer_x < `SCREEN_W) && (pointer_y < `SCREEN_H));

endmodule

`default_nettype wire

//--- src/key_hold_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "keylab_consts.svh"

module key_hold_bank
  import keylab_pkg::*;
(
  input  logic      CLK_25MHZ,
  input  logic      reset_from_key,
  input  logic      key_strobe,
  input  key_num_t  key_num,
  input  logic      key_make,
  output key_word_u held
);

  key_word_u held_q;

  //////////////////////////////////////////////////////////////////////
  // one held bit per tracked key
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      held_q.bits <= '0;
    end else if (key_strobe) begin
      held_q.bits[key_num] <= key_make;   // repeat press or stray release is a no-op
    end
  end

  assign held = held_q;

  // a bad key number from the decoder would show up here
  a_reserved_zero: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
    held.keys.reserved == '0);

endmodule

`default_nettype wire

//--- src/keylab_consts.svh
`ifndef KEYLAB_CONSTS_SVH
`define KEYLAB_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// keyboard event codes, break code is make code with bit 7 set
//////////////////////////////////////////////////////////////////////
`define SC_MAKE_DOWN_ARROW    8'h72
`define SC_BREAK_DOWN_ARROW   8'hF2
`define SC_MAKE_UP_ARROW      8'h75
`define SC_BREAK_UP_ARROW     8'hF5
`define SC_MAKE_RIGHT_ARROW   8'h74
`define SC_BREAK_RIGHT_ARROW  8'hF4
`define SC_MAKE_LEFT_ARROW    8'h6B
`define SC_BREAK_LEFT_ARROW   8'hEB
`define SC_MAKE_SPACE         8'h29
`define SC_BREAK_SPACE        8'hA9
`define SC_MAKE_M             8'h3A
`define SC_BREAK_M            8'hBA
`define SC_MAKE_N             8'h31
`define SC_BREAK_N            8'hB1
`define SC_MAKE_F2            8'h06
`define SC_BREAK_F2           8'h86
`define SC_MAKE_F1            8'h05
`define SC_BREAK_F1           8'h85
`define SC_MAKE_8             8'h3E
`define SC_BREAK_8            8'hBE
`define SC_MAKE_7             8'h3D
`define SC_BREAK_7            8'hBD
`define SC_MAKE_6             8'h36
`define SC_BREAK_6            8'hB6
`define SC_MAKE_5             8'h2E
`define SC_BREAK_5            8'hAE
`define SC_MAKE_4             8'h25
`define SC_BREAK_4            8'hA5
`define SC_MAKE_3             8'h26
`define SC_BREAK_3            8'hA6
`define SC_MAKE_2             8'h1E
`define SC_BREAK_2            8'h9E
`define SC_MAKE_1             8'h16
`define SC_BREAK_1            8'h96

//////////////////////////////////////////////////////////////////////
// key numbers, same bit order as the keyboard_keys word
//////////////////////////////////////////////////////////////////////
`define KEY_DOWN    5'd0
`define KEY_UP      5'd1
`define KEY_RIGHT   5'd2
`define KEY_LEFT    5'd3
`define KEY_SPACE   5'd4
`define KEY_M       5'd5
`define KEY_N       5'd6
`define KEY_F2      5'd7
`define KEY_F1      5'd8
`define KEY_8       5'd9
`define KEY_7       5'd10
`define KEY_6       5'd11
`define KEY_5       5'd12
`define KEY_4       5'd13
`define KEY_3       5'd14
`define KEY_2       5'd15
`define KEY_1       5'd16

`define KEY_COUNT      17
`define KEY_WORD_BITS  32

`define SCREEN_W       10'd640
`define SCREEN_H       10'd480
`define CURSOR_HOME_X  10'd320
`define CURSOR_HOME_Y  10'd240

`define PALETTE_0  12'hFFF   // white
`define PALETTE_1  12'hF00   // red
`define PALETTE_2  12'h0F0   // green
`define PALETTE_3  12'h00F   // blue

`define LFSR_SEED  5'b00001

`define DEFAULT_TICK_CYCLES       25000000   // 1 Hz at 25 MHz
`define DEFAULT_STEP_CYCLES       250000
`define DEFAULT_SLOW_STEP_CYCLES  1000000

`endif

//--- src/keylab_pkg.sv
`default_nettype none

`include "keylab_consts.svh"

package keylab_pkg;

  typedef logic [4:0] key_num_t;

  // named view of the held-key word, msb first
  typedef struct packed {
    logic [`KEY_WORD_BITS-`KEY_COUNT-1:0] reserved;
    logic key_1;
    logic key_2;
    logic key_3;
    logic key_4;
    logic key_5;
    logic key_6;
    logic key_7;
    logic key_8;
    logic f1;
    logic f2;
    logic n;
    logic m;
    logic space;
    logic left;
    logic right;
    logic up;
    logic down;   // bit 0
  } held_keys_t;

  typedef union packed {
    logic [`KEY_WORD_BITS-1:0] bits;   // indexed by key number
    held_keys_t                keys;
  } key_word_u;

endpackage

`default_nettype wire

//--- src/keylab_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "keylab_consts.svh"

module keylab_top
  import keylab_pkg::*;
#(
  parameter int unsigned tick_cycles      = `DEFAULT_TICK_CYCLES,
  parameter int unsigned step_cycles      = `DEFAULT_STEP_CYCLES,
  parameter int unsigned slow_step_cycles = `DEFAULT_SLOW_STEP_CYCLES
) (
  input  logic        CLK_25MHZ,
  input  logic        reset_from_key,
  input  logic        event_ready,
  input  logic [7:0]  event_type,
  output key_word_u   keyboard_keys,
  output logic [9:0]  pointer_x,
  output logic [9:0]  pointer_y,
  output logic [11:0] cursor_rgb,
  output logic [4:0]  lfsr_state,
  output logic        lfsr_heartbeat
);

  logic     key_strobe;
  key_num_t key_num;
  logic     key_make;

  //////////////////////////////////////////////////////////////////////
  // keyboard path
  //////////////////////////////////////////////////////////////////////
  scan_event_decoder u_decoder (
    .CLK_25MHZ      (CLK_25MHZ),
    .reset_from_key (reset_from_key),
    .event_ready    (event_ready),
    .event_type     (event_type),
    .key_strobe     (key_strobe),
    .key_num        (key_num),
    .key_make       (key_make)
  );

  key_hold_bank u_bank (
    .CLK_25MHZ      (CLK_25MHZ),
    .reset_from_key (reset_from_key),
    .key_strobe     (key_strobe),
    .key_num        (key_num),
    .key_make       (key_make),
    .held           (keyboard_keys)
  );

  cursor_mover #(
    .step_cycles      (step_cycles),
    .slow_step_cycles (slow_step_cycles)
  ) u_cursor (
    .CLK_25MHZ      (CLK_25MHZ),
    .reset_from_key (reset_from_key),
    .held           (keyboard_keys),
    .pointer_x      (pointer_x),
    .pointer_y      (pointer_y),
    .cursor_rgb     (cursor_rgb)
  );

  // led side function
  lfsr_ticker #(
    .tick_cycles (tick_cycles)
  ) u_ticker (
    .CLK_25MHZ      (CLK_25MHZ),
    .reset_from_key (reset_from_key),
    .lfsr_state     (lfsr_state),
    .lfsr_heartbeat (lfsr_heartbeat)
  );

endmodule

`default_nettype wire

//--- src/lfsr_ticker.sv
`timescale 1ns/1ns
`default_nettype none

`include "keylab_consts.svh"

module lfsr_ticker #(
  parameter int unsigned tick_cycles = `DEFAULT_TICK_CYCLES
) (
  input  logic       CLK_25MHZ,
  input  logic       reset_from_key,
  output logic [4:0] lfsr_state,
  output logic       lfsr_heartbeat
);

  localparam logic [31:0] tick_last = tick_cycles - 1;

  logic [31:0] div_cnt;
  logic        tick;

  assign tick = (div_cnt == tick_last);

  // divider
  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key || tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 32'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // x^5 + x^3 + 1, shift left, 31 states
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      lfsr_state     <= `LFSR_SEED;
      lfsr_heartbeat <= 1'b0;
    end else if (tick) begin
      lfsr_state     <= {lfsr_state[3:0], lfsr_state[4] ^ lfsr_state[2]};
      lfsr_heartbeat <= ~lfsr_heartbeat;   // led blink
    end
  end

  // all-zero state would lock up
  a_lfsr_nonzero: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
    lfsr_state != 5'd0);

endmodule

`default_nettype wire

//--- src/scan_event_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "keylab_consts.svh"

module scan_event_decoder
  import keylab_pkg::*;
(
  input  logic       CLK_25MHZ,
  input  logic       reset_from_key,
  input  logic       event_ready,
  input  logic [7:0] event_type,
  output logic       key_strobe,
  output key_num_t   key_num,
  output logic       key_make
);

  // {hit, make, key number}
  logic [6:0] dec;

  //////////////////////////////////////////////////////////////////////
  // code table lookup
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (event_type)
      `SC_MAKE_DOWN_ARROW:   dec = {1'b1, 1'b1, `KEY_DOWN};
      `SC_BREAK_DOWN_ARROW:  dec = {1'b1, 1'b0, `KEY_DOWN};
      `SC_MAKE_UP_ARROW:     dec = {1'b1, 1'b1, `KEY_UP};
      `SC_BREAK_UP_ARROW:    dec = {1'b1, 1'b0, `KEY_UP};
      `SC_MAKE_RIGHT_ARROW:  dec = {1'b1, 1'b1, `KEY_RIGHT};
      `SC_BREAK_RIGHT_ARROW: dec = {1'b1, 1'b0, `KEY_RIGHT};
      `SC_MAKE_LEFT_ARROW:   dec = {1'b1, 1'b1, `KEY_LEFT};
      `SC_BREAK_LEFT_ARROW:  dec = {1'b1, 1'b0, `KEY_LEFT};
      `SC_MAKE_SPACE:        dec = {1'b1, 1'b1, `KEY_SPACE};
      `SC_BREAK_SPACE:       dec = {1'b1, 1'b0, `KEY_SPACE};
      `SC_MAKE_M:            dec = {1'b1, 1'b1, `KEY_M};
      `SC_BREAK_M:           dec = {1'b1, 1'b0, `KEY_M};
      `SC_MAKE_N:            dec = {1'b1, 1'b1, `KEY_N};
      `SC_BREAK_N:           dec = {1'b1, 1'b0, `KEY_N};
      `SC_MAKE_F2:           dec = {1'b1, 1'b1, `KEY_F2};
      `SC_BREAK_F2:          dec = {1'b1, 1'b0, `KEY_F2};
      `SC_MAKE_F1:           dec = {1'b1, 1'b1, `KEY_F1};
      `SC_BREAK_F1:          dec = {1'b1, 1'b0, `KEY_F1};
      `SC_MAKE_8:            dec = {1'b1, 1'b1, `KEY_8};
      `SC_BREAK_8:           dec = {1'b1, 1'b0, `KEY_8};
      `SC_MAKE_7:            dec = {1'b1, 1'b1, `KEY_7};
      `SC_BREAK_7:           dec = {1'b1, 1'b0, `KEY_7};
      `SC_MAKE_6:            dec = {1'b1, 1'b1, `KEY_6};
      `SC_BREAK_6:           dec = {1'b1, 1'b0, `KEY_6};
      `SC_MAKE_5:            dec = {1'b1, 1'b1, `KEY_5};
      `SC_BREAK_5:           dec = {1'b1, 1'b0, `KEY_5};
      `SC_MAKE_4:            dec = {1'b1, 1'b1, `KEY_4};
      `SC_BREAK_4:           dec = {1'b1, 1'b0, `KEY_4};
      `SC_MAKE_3:            dec = {1'b1, 1'b1, `KEY_3};
      `SC_BREAK_3:           dec = {1'b1, 1'b0, `KEY_3};
      `SC_MAKE_2:            dec = {1'b1, 1'b1, `KEY_2};
      `SC_BREAK_2:           dec = {1'b1, 1'b0, `KEY_2};
      `SC_MAKE_1:            dec = {1'b1, 1'b1, `KEY_1};
      `SC_BREAK_1:           dec = {1'b1, 1'b0, `KEY_1};
      default:               dec = '0;   // untracked key
    endcase
  end

  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      key_strobe <= 1'b0;
    end else begin
      key_strobe <= event_ready & dec[6];
    end
  end

  // payload only loads on a hit
  always_ff @(posedge CLK_25MHZ) begin
    if (event_ready && dec[6]) begin
      key_make <= dec[5];
      key_num  <= dec[4:0];
    end
  end

  a_key_num_range: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
    key_strobe |-> (key_num < `KEY_COUNT));

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 10
) (
  output logic CLK_25MHZ,
  output logic reset_from_key
);

  initial begin
    CLK_25MHZ = 1'b0;
    forever #(period_ns / 2) CLK_25MHZ = ~CLK_25MHZ;
  end

  initial begin
    reset_from_key = 1'b1;
    repeat (reset_cycles) @(posedge CLK_25MHZ);
    #2 reset_from_key = 1'b0;   // released off the edge like other stimulus
  end

endmodule

`default_nettype wire

//--- testbench/tb_keylab.sv
`timescale 1ns/1ns
`default_nettype none

`include "keylab_consts.svh"

module tb_keylab
  import keylab_pkg::*;
();

  localparam int tick_cycles      = 20;
  localparam int step_cycles      = 8;
  localparam int slow_step_cycles = 32;
  localparam int move_limit       = 4 * slow_step_cycles;

  logic        CLK_25MHZ;
  logic        reset_from_key;
  logic        event_ready;
  logic [7:0]  event_type;
  key_word_u   keyboard_keys;
  logic [9:0]  pointer_x;
  logic [9:0]  pointer_y;
  logic [11:0] cursor_rgb;
  logic [4:0]  lfsr_state;
  logic        lfsr_heartbeat;

  logic [15:0] code_pair [0:16];   // {make, break} per key number
  logic [11:0] palette [0:3];
  logic [31:0] model_word;
  logic [31:0] rng;
  int          pal_model;
  int          tick_total = 0;
  logic        hb_prev = 1'b0;

  tb_clock_gen u_clk (
    .CLK_25MHZ      (CLK_25MHZ),
    .reset_from_key (reset_from_key)
  );

  keylab_top #(
    .tick_cycles      (tick_cycles),
    .step_cycles      (step_cycles),
    .slow_step_cycles (slow_step_cycles)
  ) u_dut (
    .CLK_25MHZ      (CLK_25MHZ),
    .reset_from_key (reset_from_key),
    .event_ready    (event_ready),
    .event_type     (event_type),
    .keyboard_keys  (keyboard_keys),
    .pointer_x      (pointer_x),
    .pointer_y      (pointer_y),
    .cursor_rgb     (cursor_rgb),
    .lfsr_state     (lfsr_state),
    .lfsr_heartbeat (lfsr_heartbeat)
  );

  // counts heartbeat toggles since reset
  always begin
    @(posedge CLK_25MHZ);
    #1;   // ahead of the test process
    if (reset_from_key) begin
      tick_total = 0;
      hb_prev    = 1'b0;
    end else if (lfsr_heartbeat != hb_prev) begin
      tick_total++;
      hb_prev = lfsr_heartbeat;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [4:0] lfsr_next(input logic [4:0] s);
    return {s[3:0], s[4] ^ s[2]};   // x^5 + x^3 + 1
  endfunction

  function automatic logic in_table(input logic [7:0] code);
    logic hit;
    hit = 1'b0;
    for (int k = 0; k < `KEY_COUNT; k++) begin
      if (code == code_pair[k][15:8] || code == code_pair[k][7:0]) hit = 1'b1;
    end
    return hit;
  endfunction

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timed out at %0t ns while waiting for %s", $time, what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping on timeout");
  endtask

  task automatic next_cycle();
    @(posedge CLK_25MHZ);
    #2;
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    @(posedge CLK_25MHZ);
    while (reset_from_key) begin
      if (n >= 50) fail_timeout("reset release");
      @(posedge CLK_25MHZ);
      n++;
    end
    #2;
  endtask

  task automatic send_event(input logic [7:0] code);
    event_ready = 1'b1;
    event_type  = code;
    next_cycle();
    event_ready = 1'b0;
  endtask

  task automatic send_key(input int key, input logic make);
    if (make && !model_word[key] && key == `KEY_SPACE) pal_model = (pal_model + 1) % 4;
    model_word[key] = make;   // repeat press or stray release leaves it as is
    send_event(make ? code_pair[key][15:8] : code_pair[key][7:0]);
  endtask

  // word shows the last event 2 cycles after its ready
  task automatic check_keys(input string what);
    next_cycle();
    check_eq(keyboard_keys.bits, model_word, what);
  endtask

  task automatic wait_pointer_move(output int cycles);
    logic [9:0] x0;
    logic [9:0] y0;
    int         n;
    x0 = pointer_x;
    y0 = pointer_y;
    n  = 0;
    while (pointer_x == x0 && pointer_y == y0) begin
      if (n >= move_limit) fail_timeout("pointer move");
      next_cycle();
      n++;
    end
    cycles = n;
  endtask

  task automatic wait_heartbeat_toggle(output int cycles);
    logic hb0;
    int   n;
    hb0 = lfsr_heartbeat;
    n   = 0;
    while (lfsr_heartbeat == hb0) begin
      if (n >= 2 * tick_cycles + 4) fail_timeout("heartbeat toggle");
      next_cycle();
      n++;
    end
    cycles = n;
  endtask

  ////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////
  task automatic test_reset_state();
    check_eq(u_dut.u_decoder.key_strobe, 1'b0, "key_strobe after reset");
    check_eq(keyboard_keys.bits, 32'd0, "keyboard_keys after reset");
    check_eq(pointer_x, `CURSOR_HOME_X, "pointer_x after reset");
    check_eq(pointer_y, `CURSOR_HOME_Y, "pointer_y after reset");
    check_eq(cursor_rgb, `PALETTE_0, "cursor_rgb after reset");
    check_eq(lfsr_state, `LFSR_SEED, "lfsr_state after reset");
    check_eq(lfsr_heartbeat, 1'b0, "lfsr_heartbeat after reset");
  endtask

  task automatic test_key_tracking();
    for (int k = 0; k < `KEY_COUNT; k++) begin
      send_key(k, 1'b1);
      check_keys($sformatf("press of key %0d", k));
      send_key(k, 1'b0);
      check_keys($sformatf("release of key %0d", k));
    end
    send_key(`KEY_N, 1'b1);
    check_keys("press of n");
    send_key(`KEY_F1, 1'b1);   // two events in flight
    send_key(`KEY_N, 1'b0);
    check_keys("back to back press and release");
    send_key(`KEY_F1, 1'b0);
    check_keys("release of f1");
  endtask

  task automatic test_ignored_input();
    logic [7:0] code;
    send_key(`KEY_2, 1'b1);
    check_keys("press of 2");
    for (int i = 0; i < 64; i++) begin
      rng  = xorshift32(rng);
      code = rng[7:0];
      if (!in_table(code)) send_event(code);
    end
    check_keys("after untracked codes");
    event_type = code_pair[`KEY_2][7:0];   // valid break code with ready held low
    repeat (3) next_cycle();
    check_eq(keyboard_keys.bits, model_word, "code without event_ready");
    send_key(`KEY_2, 1'b0);
    check_keys("release of 2");
  endtask

  task automatic test_cursor_motion();
    logic [9:0] x0;
    logic [9:0] y0;
    int         n;
    x0 = pointer_x;
    y0 = pointer_y;
    send_key(`KEY_RIGHT, 1'b1);
    send_key(`KEY_DOWN, 1'b1);
    wait_pointer_move(n);
    check_eq(pointer_x, x0 + 10'd1, "x after first step");
    check_eq(pointer_y, y0 + 10'd1, "y after first step");
    wait_pointer_move(n);
    check_eq(n, step_cycles, "fast step interval");
    check_eq(pointer_x, x0 + 10'd2, "x after second step");
    send_key(`KEY_M, 1'b1);
    next_cycle();
    wait_pointer_move(n);
    wait_pointer_move(n);
    check_eq(n, slow_step_cycles, "slow step interval");
    send_key(`KEY_M, 1'b0);
    send_key(`KEY_RIGHT, 1'b0);
    send_key(`KEY_DOWN, 1'b0);
    check_keys("arrows released");
    // left and right cancel while down still steps
    send_key(`KEY_LEFT, 1'b1);
    send_key(`KEY_RIGHT, 1'b1);
    send_key(`KEY_DOWN, 1'b1);
    next_cycle();
    x0 = pointer_x;
    for (int i = 0; i < 3; i++) begin
      y0 = pointer_y;
      wait_pointer_move(n);
      check_eq(pointer_x, x0, "x with left and right held");
      check_eq(pointer_y, y0 + 10'd1, "y with left and right held");
    end
    send_key(`KEY_LEFT, 1'b0);
    send_key(`KEY_RIGHT, 1'b0);
    send_key(`KEY_DOWN, 1'b0);
    send_key(`KEY_UP, 1'b1);
    next_cycle();
    x0 = pointer_x;
    n  = 0;
    while (pointer_y != 10'd0) begin
      if (n >= (`SCREEN_H + 4) * step_cycles) fail_timeout("pointer at top edge");
      next_cycle();
      n++;
    end
    repeat (4 * step_cycles) next_cycle();
    check_eq(pointer_y, 10'd0, "y saturates at top");
    check_eq(pointer_x, x0, "x during up motion");
    send_key(`KEY_UP, 1'b0);
    check_keys("up released");
  endtask

  task automatic test_colour_cycle();
    for (int i = 0; i < 4; i++) begin
      send_key(`KEY_SPACE, 1'b1);
      repeat (2) next_cycle();   // bank and then palette index
      check_eq(cursor_rgb, palette[pal_model], "colour after space press");
      repeat (5) next_cycle();
      check_eq(cursor_rgb, palette[pal_model], "colour while space held");
      send_key(`KEY_SPACE, 1'b0);
      repeat (2) next_cycle();
      check_eq(cursor_rgb, palette[pal_model], "colour after space release");
    end
  endtask

  task automatic test_lfsr_ticker();
    logic [4:0] model;
    int         n;
    int         done;
    wait_heartbeat_toggle(n);   // sync only
    model = `LFSR_SEED;
    for (int i = 0; i < tick_total; i++) model = lfsr_next(model);
    check_eq(lfsr_state, model, "lfsr at sync tick");
    done = 0;
    while (done < 31 || (tick_total % 31) != 0) begin
      wait_heartbeat_toggle(n);
      model = lfsr_next(model);
      check_eq(n, tick_cycles, "tick interval");
      check_eq(lfsr_state, model, "lfsr step");
      done++;
    end
    check_eq(lfsr_state, `LFSR_SEED, "lfsr back at seed after full period");
  endtask

  ////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////
  initial begin
    event_ready = 1'b0;
    event_type  = 8'h00;
    model_word  = 32'd0;
    pal_model   = 0;
    rng         = 32'hb1e4_4b2b;
    palette[0]  = `PALETTE_0;
    palette[1]  = `PALETTE_1;
    palette[2]  = `PALETTE_2;
    palette[3]  = `PALETTE_3;
    code_pair[`KEY_DOWN]  = {`SC_MAKE_DOWN_ARROW, `SC_BREAK_DOWN_ARROW};
    code_pair[`KEY_UP]    = {`SC_MAKE_UP_ARROW, `SC_BREAK_UP_ARROW};
    code_pair[`KEY_RIGHT] = {`SC_MAKE_RIGHT_ARROW, `SC_BREAK_RIGHT_ARROW};
    code_pair[`KEY_LEFT]  = {`SC_MAKE_LEFT_ARROW, `SC_BREAK_LEFT_ARROW};
    code_pair[`KEY_SPACE] = {`SC_MAKE_SPACE, `SC_BREAK_SPACE};
    code_pair[`KEY_M]     = {`SC_MAKE_M, `SC_BREAK_M};
    code_pair[`KEY_N]     = {`SC_MAKE_N, `SC_BREAK_N};
    code_pair[`KEY_F2]    = {`SC_MAKE_F2, `SC_BREAK_F2};
    code_pair[`KEY_F1]    = {`SC_MAKE_F1, `SC_BREAK_F1};
    code_pair[`KEY_8]     = {`SC_MAKE_8, `SC_BREAK_8};
    code_pair[`KEY_7]     = {`SC_MAKE_7, `SC_BREAK_7};
    code_pair[`KEY_6]     = {`SC_MAKE_6, `SC_BREAK_6};
    code_pair[`KEY_5]     = {`SC_MAKE_5, `SC_BREAK_5};
    code_pair[`KEY_4]     = {`SC_MAKE_4, `SC_BREAK_4};
    code_pair[`KEY_3]     = {`SC_MAKE_3, `SC_BREAK_3};
    code_pair[`KEY_2]     = {`SC_MAKE_2, `SC_BREAK_2};
    code_pair[`KEY_1]     = {`SC_MAKE_1, `SC_BREAK_1};

    wait_reset_release();
    test_reset_state();
    test_key_tracking();
    test_ignored_input();
    test_cursor_motion();
    test_colour_cycle();
    test_lfsr_ticker();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire
